//--- hw/ecc_pkg.sv
package ecc_pkg;

    // one lane of the SEC-DED code, 11 data bits plus 5 check bits
    localparam int data_width   = 11;
    localparam int parity_width = 5;
    localparam int code_width   = data_width + parity_width;

    // field view of a stored codeword, check bits on top
    typedef struct packed {
        logic [parity_width-1:0] parity;
        logic [data_width-1:0]   data;
    } ecc_fields_t;

    // the checker reads fields, the injection path works on the flat word
    typedef union packed {
        ecc_fields_t             fields;
        logic [code_width-1:0]   raw;
    } ecc_codeword_u;

    // every data bit sits in three or five check sets, so each column is unique
    // and differs from the one-hot parity-only syndromes
    function automatic logic [parity_width-1:0] ecc_encode(
        input logic [data_width-1:0] d
    );
        logic [parity_width-1:0] p;

        p[0] = ^{d[10], d[8], d[6], d[4], d[3], d[1], d[0]};
        p[1] = ^{d[10], d[9], d[6], d[5], d[3], d[2], d[0]};
        p[2] = ^{d[10], d[9], d[8], d[7], d[3], d[2], d[1]};
        p[3] = ^{d[10], d[9], d[8], d[7], d[6], d[5], d[4]};
        p[4] = ^{d[10], d[7], d[5], d[4], d[2], d[1], d[0]};
        return p;
    endfunction

endpackage

//--- hw/mem_pkg.sv
package mem_pkg;

    // words per lane and the address that selects them
    localparam int mem_depth   = 16;
    localparam int addr_width  = 4;

    // user word is both lanes side by side
    localparam int word_width  = 22;

    // error counters stop at all ones
    localparam int count_width = 8;

endpackage

//--- hw/ecc_lane_if.sv
`timescale 1ns/100ps

interface ecc_lane_if;

    // checked data and flags of one lane, valid for one cycle per read
    logic [ecc_pkg::data_width-1:0] data;
    logic                           sbit_err;
    logic                           dbit_err;
    logic                           valid;

    modport lane (
        output data,
        output sbit_err,
        output dbit_err,
        output valid
    );

    modport merge (
        input  data,
        input  sbit_err,
        input  dbit_err,
        input  valid
    );

endinterface

//--- hw/ecc_11_codec.sv
`timescale 1ns/100ps

module ecc_11_codec (
    input  ecc_pkg::ecc_codeword_u           code,
    input  logic                             bypass,
    output logic [ecc_pkg::data_width-1:0]   data,
    output logic                             sbit_err,
    output logic                             dbit_err
);

logic [ecc_pkg::parity_width-1:0] syndrome;
logic [ecc_pkg::data_width-1:0]   flip_mask;
logic                             parity_only;
logic                             single_err;
logic                             double_err;

assign syndrome = code.fields.parity ^ ecc_pkg::ecc_encode(code.fields.data);

// exactly one check bit set means the error hit the stored parity
assign parity_only = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

// match the syndrome against the column of each data bit
always_comb begin
    logic [ecc_pkg::data_width-1:0] probe;

    flip_mask = '0;
    for (int i = 0; i < ecc_pkg::data_width; i++) begin
        probe    = '0;
        probe[i] = 1'b1;
        if (syndrome == ecc_pkg::ecc_encode(probe)) begin
            flip_mask[i] = 1'b1;
        end
    end
end

always_comb begin
    single_err = 1'b0;
    double_err = 1'b0;
    if (flip_mask != '0 || parity_only) begin
        single_err = 1'b1;
    end else if (syndrome != '0) begin
        // even weight syndrome, cannot be located
        double_err = 1'b1;
    end
end

// a double error leaves flip_mask clear, so the data goes out as stored
assign data     = bypass ? code.fields.data : code.fields.data ^ flip_mask;
assign sbit_err = ~bypass & single_err;
assign dbit_err = ~bypass & double_err;

endmodule

//--- hw/ecc_lane.sv
`timescale 1ns/100ps

module ecc_lane (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wr_en,
    input  logic [mem_pkg::addr_width-1:0]   wr_addr,
    input  logic [ecc_pkg::data_width-1:0]   wr_data,
    input  logic [ecc_pkg::code_width-1:0]   inj_mask,
    input  logic                             rd_en,
    input  logic [mem_pkg::addr_width-1:0]   rd_addr,
    input  logic                             bypass,
    ecc_lane_if.lane                         result
);

ecc_pkg::ecc_codeword_u enc_code;
ecc_pkg::ecc_codeword_u store_code;
ecc_pkg::ecc_codeword_u mem [0:mem_pkg::mem_depth-1];
ecc_pkg::ecc_codeword_u rd_code;
logic                   rd_bypass;
logic                   rd_valid;

// encode the write data into its codeword
always_comb begin
    enc_code.fields.data   = wr_data;
    enc_code.fields.parity = ecc_pkg::ecc_encode(wr_data);
end

// injected flips land anywhere in the stored word, parity included
assign store_code.raw = enc_code.raw ^ inj_mask;

always_ff @(posedge clk) begin
    if (wr_en) begin
        mem[wr_addr] <= store_code;
    end
end

// a same-cycle write is not visible here, the read gets the old word
always_ff @(posedge clk) begin
    if (rd_en) begin
        rd_code   <= mem[rd_addr];
        rd_bypass <= bypass;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        rd_valid <= 1'b0;
    end else begin
        rd_valid <= rd_en;
    end
end

ecc_11_codec ecc_11_codec_i (
    .code     (rd_code),
    .bypass   (rd_bypass),
    .data     (result.data),
    .sbit_err (result.sbit_err),
    .dbit_err (result.dbit_err)
);

assign result.valid = rd_valid;

endmodule

//--- hw/ecc_merge.sv
`timescale 1ns/100ps

module ecc_merge (
    input  logic                              clk,
    input  logic                              reset,
    ecc_lane_if.merge                         lane_lo,
    ecc_lane_if.merge                         lane_hi,
    output logic                              rd_valid,
    output logic [mem_pkg::word_width-1:0]    rd_data,
    output logic                              sbit_err,
    output logic                              dbit_err,
    output logic [mem_pkg::count_width-1:0]   sbit_count,
    output logic [mem_pkg::count_width-1:0]   dbit_count
);

logic lanes_valid;
logic any_dbit;
logic any_sbit;

assign lanes_valid = lane_lo.valid & lane_hi.valid;

// a double error in either lane outranks a single error in the other
assign any_dbit = lanes_valid & (lane_lo.dbit_err | lane_hi.dbit_err);
assign any_sbit = lanes_valid & ~any_dbit & (lane_lo.sbit_err | lane_hi.sbit_err);

always_ff @(posedge clk) begin
    if (lanes_valid) begin
        rd_data <= {lane_hi.data, lane_lo.data};
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        rd_valid   <= 1'b0;
        sbit_err   <= 1'b0;
        dbit_err   <= 1'b0;
        sbit_count <= '0;
        dbit_count <= '0;
    end else begin
        rd_valid <= lanes_valid;
        sbit_err <= any_sbit;
        dbit_err <= any_dbit;
        // counters hold at all ones
        if (any_sbit && sbit_count != '1) begin
            sbit_count <= sbit_count + 1'b1;
        end
        if (any_dbit && dbit_count != '1) begin
            dbit_count <= dbit_count + 1'b1;
        end
    end
end

endmodule

//--- hw/ecc_mem_top.sv
`timescale 1ns/100ps

module ecc_mem_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_en,
    input  logic [mem_pkg::addr_width-1:0]      wr_addr,
    input  logic [mem_pkg::word_width-1:0]      wr_data,
    input  logic                                rd_en,
    input  logic [mem_pkg::addr_width-1:0]      rd_addr,
    input  logic                                bypass,
    input  logic [2*ecc_pkg::code_width-1:0]    inj_mask,
    output logic                                rd_valid,
    output logic [mem_pkg::word_width-1:0]      rd_data,
    output logic                                sbit_err,
    output logic                                dbit_err,
    output logic [mem_pkg::count_width-1:0]     sbit_count,
    output logic [mem_pkg::count_width-1:0]     dbit_count
);

ecc_lane_if lane_lo_if ();
ecc_lane_if lane_hi_if ();

// low half of the word and of the mask
ecc_lane lane_lo_i (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data[ecc_pkg::data_width-1:0]),
    .inj_mask (inj_mask[ecc_pkg::code_width-1:0]),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .bypass   (bypass),
    .result   (lane_lo_if.lane)
);

// high half of the word and of the mask
ecc_lane lane_hi_i (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data[mem_pkg::word_width-1:ecc_pkg::data_width]),
    .inj_mask (inj_mask[2*ecc_pkg::code_width-1:ecc_pkg::code_width]),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .bypass   (bypass),
    .result   (lane_hi_if.lane)
);

ecc_merge merge_i (
    .clk        (clk),
    .reset      (reset),
    .lane_lo    (lane_lo_if.merge),
    .lane_hi    (lane_hi_if.merge),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .sbit_err   (sbit_err),
    .dbit_err   (dbit_err),
    .sbit_count (sbit_count),
    .dbit_count (dbit_count)
);

endmodule

//--- tb/ecc_mem_sva.sv
`timescale 1ns/100ps

module ecc_mem_sva (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rd_en,
    input  logic                              rd_valid,
    input  logic                              sbit_err,
    input  logic                              dbit_err,
    input  logic [mem_pkg::count_width-1:0]   sbit_count,
    input  logic [mem_pkg::count_width-1:0]   dbit_count
);

// read latency is fixed at two cycles, both ways
read_latency: assert property (@(posedge clk) disable iff (reset) rd_en |-> ##2 rd_valid)
    else $error("rd_valid missing two cycles after rd_en");

valid_source: assert property (@(posedge clk) disable iff (reset) rd_valid |-> $past(rd_en, 2))
    else $error("rd_valid without rd_en two cycles earlier");

flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(sbit_err && dbit_err))
    else $error("sbit_err and dbit_err high together");

flags_idle: assert property (@(posedge clk) disable iff (reset)
    !rd_valid |-> (!sbit_err && !dbit_err))
    else $error("error flag high outside a read result");

// counters only move up between resets
sbit_monotonic: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> sbit_count >= $past(sbit_count))
    else $error("sbit_count decreased");

dbit_monotonic: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> dbit_count >= $past(dbit_count))
    else $error("dbit_count decreased");

endmodule

//--- tb/ecc_mem_tb.sv
`timescale 1ns/100ps

module ecc_mem_tb;

logic                                  clk;
logic                                  reset;
logic                                  wr_en;
logic [mem_pkg::addr_width-1:0]        wr_addr;
logic [mem_pkg::word_width-1:0]        wr_data;
logic                                  rd_en;
logic [mem_pkg::addr_width-1:0]        rd_addr;
logic                                  bypass;
logic [2*ecc_pkg::code_width-1:0]      inj_mask;
logic                                  rd_valid;
logic [mem_pkg::word_width-1:0]        rd_data;
logic                                  sbit_err;
logic                                  dbit_err;
logic [mem_pkg::count_width-1:0]       sbit_count;
logic [mem_pkg::count_width-1:0]       dbit_count;

// stored codewords of both lanes as they sit in the DUT, hi lane on top
logic [31:0] shadow [0:15];
// entry: dbit count, sbit count, dbit, sbit, data
logic [39:0] expected_q [$];
logic [39:0] head;
logic [7:0]  model_sbit;
logic [7:0]  model_dbit;
logic [15:0] lfsr_state;
int          cycle_count;

logic        r_wr;
logic [3:0]  r_waddr;
logic [21:0] r_wdata;
logic [3:0]  kind_lo;
logic [3:0]  kind_hi;
logic [15:0] mask_lo;
logic [15:0] mask_hi;
logic [3:0]  r_raddr;
logic        r_byp;

ecc_mem_top ecc_mem_top_i (
    .clk        (clk),
    .reset      (reset),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .bypass     (bypass),
    .inj_mask   (inj_mask),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .sbit_err   (sbit_err),
    .dbit_err   (dbit_err),
    .sbit_count (sbit_count),
    .dbit_count (dbit_count)
);

bind ecc_mem_top ecc_mem_sva ecc_mem_sva_i (
    .clk        (clk),
    .reset      (reset),
    .rd_en      (rd_en),
    .rd_valid   (rd_valid),
    .sbit_err   (sbit_err),
    .dbit_err   (dbit_err),
    .sbit_count (sbit_count),
    .dbit_count (dbit_count)
);

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("[FAIL] time %0t: %s got %0h expected %0h", $time, name, got, want);
    $display("Test FAILED");
    $fatal(1);
endtask

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
endtask

// 16 bit Galois register, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;

    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// check bit equations of the SEC-DED code
function automatic logic [4:0] parity_of(input logic [10:0] d);
    logic [4:0] p;

    p[0] = d[10] ^ d[8] ^ d[6] ^ d[4] ^ d[3] ^ d[1] ^ d[0];
    p[1] = d[10] ^ d[9] ^ d[6] ^ d[5] ^ d[3] ^ d[2] ^ d[0];
    p[2] = d[10] ^ d[9] ^ d[8] ^ d[7] ^ d[3] ^ d[2] ^ d[1];
    p[3] = d[10] ^ d[9] ^ d[8] ^ d[7] ^ d[6] ^ d[5] ^ d[4];
    p[4] = d[10] ^ d[7] ^ d[5] ^ d[4] ^ d[2] ^ d[1] ^ d[0];
    return p;
endfunction

// returns dbit, sbit and the corrected data of one lane
function automatic logic [12:0] check_lane(input logic [15:0] code, input logic byp);
    logic [4:0]  syn;
    logic [10:0] data;
    logic        sbit;
    logic        dbit;

    data = code[10:0];
    syn  = code[15:11] ^ parity_of(code[10:0]);
    sbit = 1'b0;
    dbit = 1'b0;
    if (!byp && syn != 5'd0) begin
        if ($countones(syn) == 1) begin
            sbit = 1'b1;
        end else begin
            dbit = 1'b1;
            for (int i = 0; i < 11; i++) begin
                if (parity_of(11'd1 << i) == syn) begin
                    data[i] = ~data[i];
                    sbit    = 1'b1;
                    dbit    = 1'b0;
                end
            end
        end
    end
    return {dbit, sbit, data};
endfunction

function automatic logic [23:0] expected_result(input logic [31:0] word, input logic byp);
    logic [12:0] lo;
    logic [12:0] hi;
    logic        dbit;
    logic        sbit;

    lo   = check_lane(word[15:0], byp);
    hi   = check_lane(word[31:16], byp);
    dbit = lo[12] | hi[12];
    sbit = ~dbit & (lo[11] | hi[11]);
    return {dbit, sbit, hi[10:0], lo[10:0]};
endfunction

// kind 0..2 clean, 3..14 one flip, 15 two flips
function automatic logic [15:0] lane_mask(input logic [3:0] kind);
    logic [3:0]  p1;
    logic [3:0]  step;
    logic [3:0]  p2;
    logic [15:0] m;

    m = '0;
    if (kind >= 4'd3 && kind <= 4'd14) begin
        p1    = 4'(random_bits(4));
        m[p1] = 1'b1;
    end else if (kind == 4'd15) begin
        p1    = 4'(random_bits(4));
        step  = 4'(random_bits(4));
        p2    = p1 + 4'd1 + (step % 4'd15);
        m[p1] = 1'b1;
        m[p2] = 1'b1;
    end
    return m;
endfunction

// drive one cycle of inputs and update the model, read before write
task automatic apply_cycle(input logic wr, input logic [3:0] waddr, input logic [21:0] wdata,
                           input logic [31:0] mask, input logic rd, input logic [3:0] raddr,
                           input logic byp);
    logic [23:0] res;

    wr_en    = wr;
    wr_addr  = waddr;
    wr_data  = wdata;
    inj_mask = mask;
    rd_en    = rd;
    rd_addr  = raddr;
    bypass   = byp;
    if (rd) begin
        res = expected_result(shadow[raddr], byp);
        if (res[23] && model_dbit != 8'hff) begin
            model_dbit = model_dbit + 8'd1;
        end
        if (res[22] && model_sbit != 8'hff) begin
            model_sbit = model_sbit + 8'd1;
        end
        expected_q.push_back({model_dbit, model_sbit, res});
    end
    if (wr) begin
        shadow[waddr] = {parity_of(wdata[21:11]), wdata[21:11],
                         parity_of(wdata[10:0]), wdata[10:0]} ^ mask;
    end
    @(negedge clk);
endtask

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 2000) begin
        abort_run("timeout: the run did not finish within 2000 cycles");
    end
end

always @(negedge clk) begin
    if (!reset && rd_valid) begin
        if (expected_q.size() == 0) begin
            abort_run("rd_valid came with no read outstanding");
        end else begin
            head = expected_q.pop_front();
            assert (rd_data == head[21:0])
                else report_mismatch("rd_data", 32'(rd_data), 32'(head[21:0]));
            assert (sbit_err == head[22])
                else report_mismatch("sbit_err", 32'(sbit_err), 32'(head[22]));
            assert (dbit_err == head[23])
                else report_mismatch("dbit_err", 32'(dbit_err), 32'(head[23]));
            assert (sbit_count == head[31:24])
                else report_mismatch("sbit_count", 32'(sbit_count), 32'(head[31:24]));
            assert (dbit_count == head[39:32])
                else report_mismatch("dbit_count", 32'(dbit_count), 32'(head[39:32]));
        end
    end
end

initial begin
    lfsr_state  = 16'd23;
    cycle_count = 0;
    model_sbit  = '0;
    model_dbit  = '0;
    reset       = 1'b1;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    rd_en       = 1'b0;
    rd_addr     = '0;
    bypass      = 1'b0;
    inj_mask    = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // clean fill of every address
    for (int a = 0; a < 16; a++) begin
        apply_cycle(1'b1, 4'(a), 22'(random_bits(22)), 32'h0, 1'b0, 4'd0, 1'b0);
    end
    for (int a = 0; a < 4; a++) begin
        apply_cycle(1'b0, 4'd0, 22'd0, 32'h0, 1'b1, 4'(a), 1'b0);
    end

    // lo data bit, hi data bit, lo parity bit
    apply_cycle(1'b1, 4'd1, 22'(random_bits(22)), 32'h0000_0020, 1'b0, 4'd0, 1'b0);
    apply_cycle(1'b1, 4'd2, 22'(random_bits(22)), 32'h0008_0000, 1'b1, 4'd1, 1'b0);
    apply_cycle(1'b1, 4'd3, 22'(random_bits(22)), 32'h0000_2000, 1'b1, 4'd2, 1'b0);
    // double in lo with a single in hi, then the same word bypassed
    apply_cycle(1'b1, 4'd4, 22'(random_bits(22)), 32'h0010_1001, 1'b1, 4'd3, 1'b0);
    apply_cycle(1'b0, 4'd0, 22'd0, 32'h0, 1'b1, 4'd4, 1'b0);
    apply_cycle(1'b0, 4'd0, 22'd0, 32'h0, 1'b1, 4'd4, 1'b1);
    // same address read and write returns the old word
    apply_cycle(1'b1, 4'd5, 22'(random_bits(22)), 32'h0, 1'b1, 4'd5, 1'b0);
    apply_cycle(1'b0, 4'd0, 22'd0, 32'h0, 1'b1, 4'd5, 1'b0);

    for (int n = 0; n < 480; n++) begin
        r_wr    = random_bits(1) != 0;
        r_waddr = 4'(random_bits(4));
        r_wdata = 22'(random_bits(22));
        kind_lo = 4'(random_bits(4));
        kind_hi = 4'(random_bits(4));
        mask_lo = lane_mask(kind_lo);
        mask_hi = lane_mask(kind_hi);
        r_raddr = 4'(random_bits(4));
        r_byp   = random_bits(4) == 0;
        apply_cycle(r_wr, r_waddr, r_wdata, {mask_hi, mask_lo}, 1'b1, r_raddr, r_byp);
    end
    apply_cycle(1'b0, 4'd0, 22'd0, 32'h0, 1'b0, 4'd0, 1'b0);
    while (expected_q.size() != 0) begin
        @(negedge clk);
    end

    assert (model_sbit == 8'hff)
        else abort_run("the random mix never drove the single error count to saturation");
    assert (sbit_count == model_sbit)
        else report_mismatch("sbit_count", 32'(sbit_count), 32'(model_sbit));
    assert (dbit_count == model_dbit)
        else report_mismatch("dbit_count", 32'(dbit_count), 32'(model_dbit));
    $display("Test OK");
    $finish;
end

endmodule

//--- tb.f
hw/ecc_pkg.sv
hw/mem_pkg.sv
hw/ecc_lane_if.sv
hw/ecc_11_codec.sv
hw/ecc_lane.sv
hw/ecc_merge.sv
hw/ecc_mem_top.sv
tb/ecc_mem_sva.sv
tb/ecc_mem_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ecc_mem_tb -f tb.f \
    -o ecc_mem_sim && ./obj_dir/ecc_mem_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
